// File: design/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath widths
`define CPU_DATA_W   32
`define CPU_REG_AW   5
`define CPU_IMM_W    16
`define CPU_SHAMT_W  5
`define CPU_OP_W     6
`define CPU_FUNCT_W  6

// opcodes
`define CPU_OP_RTYPE 6'h00
`define CPU_OP_ADDI  6'h08
`define CPU_OP_ANDI  6'h0c
`define CPU_OP_ORI   6'h0d
`define CPU_OP_XORI  6'h0e

// r-type functs
`define CPU_FN_SLL   6'h00
`define CPU_FN_ADD   6'h20
`define CPU_FN_SUB   6'h22
`define CPU_FN_AND   6'h24
`define CPU_FN_OR    6'h25
`define CPU_FN_XOR   6'h26
`define CPU_FN_SLT   6'h2a

`endif

// File: design/cpu_pkg.sv
package cpu_pkg;

  `include "cpu_consts.svh"

  ////////////////////
  // instruction views

  typedef struct packed {
    logic [`CPU_OP_W-1:0]    opcode;
    logic [`CPU_REG_AW-1:0]  rs;
    logic [`CPU_REG_AW-1:0]  rt;
    logic [`CPU_REG_AW-1:0]  rd;
    logic [`CPU_SHAMT_W-1:0] shamt;
    logic [`CPU_FUNCT_W-1:0] funct;
  } r_fields_t;

  typedef struct packed {
    logic [`CPU_OP_W-1:0]   opcode;
    logic [`CPU_REG_AW-1:0] rs;
    logic [`CPU_REG_AW-1:0] rt;
    logic [`CPU_IMM_W-1:0]  imm;
  } i_fields_t;

  // one word decoded both ways
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_t;

  ////////////////////
  // pipeline payloads

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll
  } alu_op_t;

  typedef struct packed {
    alu_op_t                 alu_op;
    logic                    use_imm;
    logic [`CPU_REG_AW-1:0]  rs;
    logic [`CPU_REG_AW-1:0]  rt;
    logic [`CPU_REG_AW-1:0]  dest;
    logic [`CPU_IMM_W-1:0]   imm;
    logic [`CPU_SHAMT_W-1:0] shamt;
    logic [`CPU_DATA_W-1:0]  rs_data;
    logic [`CPU_DATA_W-1:0]  rt_data;
  } ex_ctrl_t;

  typedef struct packed {
    logic [`CPU_REG_AW-1:0] dest;
    logic [`CPU_DATA_W-1:0] result;
  } retire_t;

endpackage

// File: design/alu.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module alu import cpu_pkg::*; (
  input  alu_op_t                 op,
  input  logic [`CPU_DATA_W-1:0]  a,
  input  logic [`CPU_DATA_W-1:0]  b,
  input  logic [`CPU_SHAMT_W-1:0] shamt,
  output logic [`CPU_DATA_W-1:0]  result
);

  logic lt;

  // signed compare for slt
  assign lt = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_xor: result = a ^ b;
      alu_slt: result = {{(`CPU_DATA_W-1){1'b0}}, lt};
      // shifts the rt operand
      alu_sll: result = b << shamt;
      default: result = a + b;
    endcase
  end

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module register_file (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`CPU_REG_AW-1:0] rs_addr,
  input  logic [`CPU_REG_AW-1:0] rt_addr,
  output logic [`CPU_DATA_W-1:0] rs_data,
  output logic [`CPU_DATA_W-1:0] rt_data,
  input  logic                   wr_en,
  input  logic [`CPU_REG_AW-1:0] wr_addr,
  input  logic [`CPU_DATA_W-1:0] wr_data
);

  logic [`CPU_DATA_W-1:0] regs [32];
  logic                   wr_live;

  // r0 stays zero
  assign wr_live = wr_en && (wr_addr != '0);

  // same-cycle write shows through to the reader
  assign rs_data = (wr_live && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
  assign rt_data = (wr_live && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module decode_stage import cpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   instr_valid,
  output logic                   instr_ready,
  input  instr_t                 instr,
  output logic [`CPU_REG_AW-1:0] rs_addr,
  output logic [`CPU_REG_AW-1:0] rt_addr,
  input  logic [`CPU_DATA_W-1:0] rs_data,
  input  logic [`CPU_DATA_W-1:0] rt_data,
  output logic                   ex_valid,
  input  logic                   ex_ready,
  output ex_ctrl_t               ex_ctrl
);

  logic     if_valid;
  instr_t   if_instr;
  logic     ex_take;
  ex_ctrl_t dec;

  // output slot is free or draining this cycle
  assign ex_take     = !ex_valid || ex_ready;
  assign instr_ready = !if_valid || ex_take;

  assign rs_addr = if_instr.i.rs;
  assign rt_addr = if_instr.i.rt;

  ////////////////////
  // decoder

  always_comb begin
    dec         = '0;
    dec.alu_op  = alu_add;
    dec.rs      = if_instr.i.rs;
    dec.rt      = if_instr.i.rt;
    dec.imm     = if_instr.i.imm;
    dec.shamt   = if_instr.r.shamt;
    dec.rs_data = rs_data;
    dec.rt_data = rt_data;
    case (if_instr.r.opcode)
      `CPU_OP_RTYPE: begin
        dec.dest = if_instr.r.rd;
        case (if_instr.r.funct)
          `CPU_FN_SLL: dec.alu_op = alu_sll;
          `CPU_FN_ADD: dec.alu_op = alu_add;
          `CPU_FN_SUB: dec.alu_op = alu_sub;
          `CPU_FN_AND: dec.alu_op = alu_and;
          `CPU_FN_OR:  dec.alu_op = alu_or;
          `CPU_FN_XOR: dec.alu_op = alu_xor;
          `CPU_FN_SLT: dec.alu_op = alu_slt;
          default:     dec.dest   = '0;
        endcase
      end
      `CPU_OP_ADDI: begin
        dec.use_imm = 1'b1;
        dec.dest    = if_instr.i.rt;
        dec.alu_op  = alu_add;
      end
      `CPU_OP_ANDI: begin
        dec.use_imm = 1'b1;
        dec.dest    = if_instr.i.rt;
        dec.alu_op  = alu_and;
      end
      `CPU_OP_ORI: begin
        dec.use_imm = 1'b1;
        dec.dest    = if_instr.i.rt;
        dec.alu_op  = alu_or;
      end
      `CPU_OP_XORI: begin
        dec.use_imm = 1'b1;
        dec.dest    = if_instr.i.rt;
        dec.alu_op  = alu_xor;
      end
      // unknown opcode becomes a write to r0
      default:      dec.dest = '0;
    endcase
  end

  ////////////////////
  // pipeline registers

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_valid <= 1'b0;
      if_instr <= '0;
      ex_valid <= 1'b0;
      ex_ctrl  <= '0;
    end else begin
      if (instr_ready) begin
        if_valid <= instr_valid;
        if (instr_valid) if_instr <= instr;
      end
      if (ex_take) begin
        ex_valid <= if_valid;
        // operands sampled as the slot moves on
        if (if_valid) ex_ctrl <= dec;
      end
    end
  end

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module execute_stage import cpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ex_valid,
  output logic                   ex_ready,
  input  ex_ctrl_t               ex_ctrl,
  output logic                   retire_valid,
  input  logic                   retire_ready,
  output retire_t                retire,
  output logic                   wr_en,
  output logic [`CPU_REG_AW-1:0] wr_addr,
  output logic [`CPU_DATA_W-1:0] wr_data
);

  logic                   fwd_rs;
  logic                   fwd_rt;
  logic [`CPU_DATA_W-1:0] op_a;
  logic [`CPU_DATA_W-1:0] op_rt;
  logic [`CPU_DATA_W-1:0] op_b;
  logic [`CPU_DATA_W-1:0] alu_result;

  ////////////////////
  // forwarding

  // the writeback register holds the instruction just ahead
  assign fwd_rs = retire_valid && (retire.dest != '0) && (retire.dest == ex_ctrl.rs);
  assign fwd_rt = retire_valid && (retire.dest != '0) && (retire.dest == ex_ctrl.rt);

  assign op_a  = fwd_rs ? retire.result : ex_ctrl.rs_data;
  assign op_rt = fwd_rt ? retire.result : ex_ctrl.rt_data;

  // immediates are zero-extended
  assign op_b = ex_ctrl.use_imm ? {{(`CPU_DATA_W-`CPU_IMM_W){1'b0}}, ex_ctrl.imm} : op_rt;

  alu alu0 (
    .op     (ex_ctrl.alu_op),
    .a      (op_a),
    .b      (op_b),
    .shamt  (ex_ctrl.shamt),
    .result (alu_result)
  );

  ////////////////////
  // writeback register

  assign ex_ready = !retire_valid || retire_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_valid <= 1'b0;
      retire       <= '0;
    end else if (ex_ready) begin
      retire_valid <= ex_valid;
      if (ex_valid) begin
        retire.dest   <= ex_ctrl.dest;
        retire.result <= alu_result;
      end
    end
  end

  // register file commits on the retire handshake
  assign wr_en   = retire_valid && retire_ready;
  assign wr_addr = retire.dest;
  assign wr_data = retire.result;

endmodule

// File: design/cpu_core.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module cpu_core import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     instr_valid,
  output logic     instr_ready,
  input  instr_t   instr,
  output logic     retire_valid,
  input  logic     retire_ready,
  output retire_t  retire
);

  // decode to register file
  logic [`CPU_REG_AW-1:0] rs_addr;
  logic [`CPU_REG_AW-1:0] rt_addr;
  logic [`CPU_DATA_W-1:0] rs_data;
  logic [`CPU_DATA_W-1:0] rt_data;

  // decode to execute
  logic     ex_valid;
  logic     ex_ready;
  ex_ctrl_t ex_ctrl;

  // writeback port
  logic                   wr_en;
  logic [`CPU_REG_AW-1:0] wr_addr;
  logic [`CPU_DATA_W-1:0] wr_data;

  decode_stage decode0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .instr       (instr),
    .rs_addr     (rs_addr),
    .rt_addr     (rt_addr),
    .rs_data     (rs_data),
    .rt_data     (rt_data),
    .ex_valid    (ex_valid),
    .ex_ready    (ex_ready),
    .ex_ctrl     (ex_ctrl)
  );

  register_file regfile0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  execute_stage execute0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_valid     (ex_valid),
    .ex_ready     (ex_ready),
    .ex_ctrl      (ex_ctrl),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire       (retire),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data)
  );

endmodule

// File: sim/cpu_checker.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module cpu_checker import cpu_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    instr_valid,
  input  logic    instr_ready,
  input  instr_t  instr,
  input  logic    retire_valid,
  input  logic    retire_ready,
  input  retire_t retire,
  output int      accepted_count,
  output int      retired_count,
  output int      err_count,
  output logic    idle_checked
);

  logic [`CPU_DATA_W-1:0] model_regs [32];
  retire_t                expect_q [$];
  logic                   known_q [$];
  logic                   after_reset;
  int                     n_acc = 0;
  int                     n_ret = 0;
  int                     n_err = 0;

  ////////////////////
  // reference model

  task automatic run_model(input instr_t w);
    logic [`CPU_DATA_W-1:0] a;
    logic [`CPU_DATA_W-1:0] b;
    logic [`CPU_DATA_W-1:0] imm;
    retire_t                res;
    logic                   known;
    a          = model_regs[w.r.rs];
    b          = model_regs[w.r.rt];
    imm        = {{(`CPU_DATA_W-`CPU_IMM_W){1'b0}}, w.i.imm};
    known      = 1'b1;
    res.dest   = w.i.rt;
    res.result = '0;
    case (w.r.opcode)
      `CPU_OP_RTYPE: begin
        res.dest = w.r.rd;
        case (w.r.funct)
          `CPU_FN_ADD: res.result = a + b;
          `CPU_FN_SUB: res.result = a - b;
          `CPU_FN_AND: res.result = a & b;
          `CPU_FN_OR:  res.result = a | b;
          `CPU_FN_XOR: res.result = a ^ b;
          `CPU_FN_SLT: res.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          `CPU_FN_SLL: res.result = b << w.r.shamt;
          default:     known = 1'b0;
        endcase
      end
      `CPU_OP_ADDI: res.result = a + imm;
      `CPU_OP_ANDI: res.result = a & imm;
      `CPU_OP_ORI:  res.result = a | imm;
      `CPU_OP_XORI: res.result = a ^ imm;
      default:      known = 1'b0;
    endcase
    // unsupported work lands on r0 with no defined value
    if (!known) res.dest = '0;
    if (res.dest != '0) model_regs[res.dest] = res.result;
    expect_q.push_back(res);
    known_q.push_back(known);
  endtask

  task automatic check_retire(input retire_t got);
    retire_t want;
    logic    known;
    if (expect_q.size() == 0) begin
      $display("retire at %0t with no instruction outstanding", $time);
      n_err++;
    end else begin
      want  = expect_q.pop_front();
      known = known_q.pop_front();
      if (got.dest !== want.dest) begin
        $display("** Error: retire.dest expected 0x%0h got 0x%0h", want.dest, got.dest);
        n_err++;
      end
      if (known && got.result !== want.result) begin
        $display("** Error: retire.result expected 0x%08h got 0x%08h",
                 want.result, got.result);
        n_err++;
      end
    end
  endtask

  ////////////////////
  // handshake watch

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
      end
      expect_q.delete();
      known_q.delete();
      after_reset = 1'b1;
      idle_checked <= 1'b0;
    end else begin
      // first edge out of reset
      if (after_reset) begin
        if (retire_valid !== 1'b0) begin
          $display("** Error: retire_valid expected 0x0 got 0x%0h", retire_valid);
          n_err++;
        end
        if (instr_ready !== 1'b1) begin
          $display("** Error: instr_ready expected 0x1 got 0x%0h", instr_ready);
          n_err++;
        end
        after_reset = 1'b0;
        idle_checked <= 1'b1;
      end
      if (instr_valid && instr_ready) begin
        run_model(instr);
        n_acc++;
      end
      if (retire_valid && retire_ready) begin
        check_retire(retire);
        n_ret++;
      end
    end
    accepted_count <= n_acc;
    retired_count  <= n_ret;
    err_count      <= n_err;
  end

endmodule

// File: sim/tb_cpu_core.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module tb_cpu_core import cpu_pkg::*; ();

  localparam int WAIT_LIMIT = 400;

  logic    clk;
  logic    rst_n;
  logic    instr_valid;
  logic    instr_ready;
  instr_t  instr;
  logic    retire_valid;
  logic    retire_ready;
  retire_t retire;
  logic    rand_ready;
  logic    idle_checked;
  logic    timed_out;
  int      accepted_count;
  int      retired_count;
  int      err_count;
  int      errs_before;
  int      tests_failed;
  integer  seed;

  cpu_core dut0 (.*);

  cpu_checker chk0 (.*);

  always #50 clk = ~clk;

  ////////////////////
  // stimulus helpers

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  function automatic logic [4:0] rand_reg(input logic nonzero);
    logic [31:0] r;
    r = next_rand();
    if (nonzero && r[4:0] == 5'd0) return 5'd1;
    return r[4:0];
  endfunction

  // kind 0 r-type, 1 immediate, 2 either
  function automatic instr_t make_instr(input int kind, input logic [4:0] rs, rt, dest);
    instr_t      w;
    logic [31:0] r;
    r = next_rand();
    if (kind == 0 || (kind == 2 && r[8])) begin
      w.r.opcode = `CPU_OP_RTYPE;
      w.r.rs     = rs;
      w.r.rt     = rt;
      w.r.rd     = dest;
      w.r.shamt  = r[4:0];
      case (r[7:5])
        3'd0:    w.r.funct = `CPU_FN_SLL;
        3'd1:    w.r.funct = `CPU_FN_SUB;
        3'd2:    w.r.funct = `CPU_FN_AND;
        3'd3:    w.r.funct = `CPU_FN_OR;
        3'd4:    w.r.funct = `CPU_FN_XOR;
        3'd5:    w.r.funct = `CPU_FN_SLT;
        default: w.r.funct = `CPU_FN_ADD;
      endcase
    end else begin
      case (r[10:9])
        2'd0:    w.i.opcode = `CPU_OP_ADDI;
        2'd1:    w.i.opcode = `CPU_OP_ANDI;
        2'd2:    w.i.opcode = `CPU_OP_ORI;
        default: w.i.opcode = `CPU_OP_XORI;
      endcase
      w.i.rs  = rs;
      w.i.rt  = dest;
      w.i.imm = r[31:16];
    end
    return w;
  endfunction

  // opcode or funct outside the supported set
  function automatic instr_t make_unsupported();
    instr_t w;
    w = next_rand();
    if (w.r.shamt[0]) begin
      w.r.opcode = `CPU_OP_RTYPE;
      w.r.funct  = 6'h3f;
    end else begin
      w.r.opcode = 6'h3f;
    end
    return w;
  endfunction

  task automatic note_timeout(input string what);
    timed_out = 1'b1;
    $display("timeout: %s", what);
  endtask

  // one clock with retire back-pressure
  task automatic tick();
    logic [31:0] r;
    @(posedge clk);
    r = next_rand();
    retire_ready <= !rand_ready || r[0];
  endtask

  task automatic send_instr(input instr_t w);
    int waited = 0;
    if (timed_out) return;
    instr_valid <= 1'b1;
    instr       <= w;
    do begin
      tick();
      waited++;
    end while (!instr_ready && waited < WAIT_LIMIT);
    instr_valid <= 1'b0;
    if (!instr_ready) note_timeout("instruction port never became ready");
  endtask

  task automatic wait_idle();
    int waited = 0;
    do begin
      tick();
      waited++;
    end while (!idle_checked && waited < WAIT_LIMIT);
    if (!idle_checked) note_timeout("state after reset was never checked");
  endtask

  task automatic wait_drain();
    int waited = 0;
    if (timed_out) return;
    do begin
      tick();
      waited++;
    end while (retired_count != accepted_count && waited < WAIT_LIMIT);
    if (retired_count != accepted_count) note_timeout("results never left the retire port");
  endtask

  task automatic close_test(input int num, input string name);
    int errs;
    wait_drain();
    errs        = err_count - errs_before;
    errs_before = err_count;
    if (errs != 0 || timed_out) tests_failed++;
    $display("test %0d %s: %0d errors, %0d retired so far", num, name, errs, retired_count);
  endtask

  ////////////////////
  // test sequence

  initial begin
    logic [4:0]  d1;
    logic [4:0]  d2;
    logic [4:0]  d_new;
    logic [31:0] r;
    seed         = 32'h77e0_5ef8;
    clk          = 1'b0;
    rst_n        = 1'b0;
    instr_valid  = 1'b0;
    instr        = '0;
    retire_ready = 1'b1;
    rand_ready   = 1'b0;
    timed_out    = 1'b0;
    errs_before  = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    wait_idle();
    close_test(1, "reset state");

    repeat (300) send_instr(make_instr(0, rand_reg(1'b0), rand_reg(1'b0), rand_reg(1'b0)));
    close_test(2, "r-type");

    repeat (200) send_instr(make_instr(1, rand_reg(1'b0), rand_reg(1'b0), rand_reg(1'b0)));
    close_test(3, "immediate");

    // sources taken from the last two destinations
    d1 = 5'd1;
    d2 = 5'd2;
    repeat (200) begin
      r     = next_rand();
      d_new = rand_reg(1'b1);
      send_instr(make_instr(2, r[0] ? d1 : d2, r[1] ? d1 : d2, d_new));
      d2 = d1;
      d1 = d_new;
    end
    close_test(4, "dependency chains");

    repeat (100) begin
      send_instr(make_instr(2, rand_reg(1'b0), rand_reg(1'b0), 5'd0));
      send_instr(make_instr(2, 5'd0, 5'd0, rand_reg(1'b1)));
      // unsupported work also lands on r0
      send_instr(make_unsupported());
    end
    close_test(5, "register 0");

    rand_ready = 1'b1;
    repeat (300) begin
      r = next_rand();
      repeat (r[1:0]) tick();
      send_instr(make_instr(2, rand_reg(1'b0), rand_reg(1'b0), rand_reg(1'b0)));
    end
    close_test(6, "back-pressure");

    $display("%0d of 6 tests failed, %0d accepted, %0d retired, %0d errors",
             tests_failed, accepted_count, retired_count, err_count);
    if (err_count == 0 && tests_failed == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+design
design/cpu_pkg.sv
design/alu.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/cpu_core.sv
sim/cpu_checker.sv
sim/tb_cpu_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_cpu_core
FILELIST  := src.f
FLAGS     := --binary --timing -j 0
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
HEADERS   := $(wildcard design/*.svh)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
PASS_MSG  := Test completed successfully

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
